// ==== hdl/dg_config.svh ====
`ifndef DG_CONFIG_SVH
`define DG_CONFIG_SVH

`define DG_GRID_X       4                                   // Units per round
`define DG_ROUNDS       3                                   // Measurement rounds kept
`define DG_EDGE_WEIGHT  2                                   // Growth of a fully grown edge

`define DG_UNITS        (`DG_GRID_X * `DG_ROUNDS)
`define DG_H_EDGES      ((`DG_GRID_X - 1) * `DG_ROUNDS)     // Links inside a round
`define DG_V_EDGES      (`DG_GRID_X * (`DG_ROUNDS - 1))     // Links between rounds
`define DG_EDGES        (`DG_H_EDGES + `DG_V_EDGES)

`define DG_ADDR_W       $clog2(`DG_UNITS)
`define DG_GROWTH_W     $clog2(`DG_EDGE_WEIGHT + 1)

// Enough cycles for a root to walk across the whole grid
`define DG_MERGE_CYCLES `DG_UNITS

`endif

// ==== hdl/dg_pkg.sv ====
`include "dg_config.svh"

package dg_pkg;

    // Unit address is round * DG_GRID_X + column
    typedef logic [`DG_ADDR_W-1:0] unit_addr_t;

    typedef logic [`DG_GROWTH_W-1:0] growth_t;

    typedef logic [`DG_UNITS-1:0] unit_vec_t;

    // In-round links first (round, then column c to c+1),
    // then links between rounds (lower round, then column)
    typedef logic [`DG_EDGES-1:0] edge_vec_t;

    typedef logic [$clog2(`DG_MERGE_CYCLES + 1)-1:0] merge_cnt_t;

    typedef enum logic [1:0] {
        IDLE  = 2'd0,
        GROW  = 2'd1,
        MERGE = 2'd2,
        DONE  = 2'd3
    } dg_stage_e;

endpackage

// ==== hdl/dg_grid_if.sv ====
`timescale 1ns/1ps

interface dg_grid_if;
    import dg_pkg::*;

    dg_stage_e stage;                                       // Global stage from the FSM
    logic      clear;                                       // Load strobe, one cycle
    unit_vec_t unit_active;                                 // Cluster active per unit
    edge_vec_t edge_grown;                                  // Fully grown per link

    modport ctrl (
        output stage,
        output clear
    );

    modport units (
        input  stage,
        input  clear,
        input  edge_grown,
        output unit_active
    );

    modport edges (
        input  stage,
        input  clear,
        input  unit_active,
        output edge_grown
    );

endinterface

// ==== hdl/dg_stage_ctrl.sv ====
`timescale 1ns/1ps

module dg_stage_ctrl (
    input  logic    clk,
    input  logic    rst_n_i,
    input  logic    load_i,
    input  logic    run_i,
    input  logic    merge_last_i,
    output logic    start_o,
    output logic    busy_o,
    output logic    done_o,
    dg_grid_if.ctrl grid
);
    import dg_pkg::*;

    dg_stage_e state_q;
    dg_stage_e state_d;
    logic      load_ok;
    logic      run_ok;

    // Strobes only count while idle, load wins over run
    assign load_ok = (state_q == IDLE) && load_i;
    assign run_ok  = (state_q == IDLE) && run_i && !load_i;

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE:    if (run_ok) state_d = GROW;
            GROW:    state_d = MERGE;                       // Single grow step
            MERGE:   if (merge_last_i) state_d = DONE;
            DONE:    state_d = IDLE;
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q    <= IDLE;
            grid.clear <= 1'b0;
            start_o    <= 1'b0;
        end else begin
            state_q    <= state_d;
            grid.clear <= load_ok;                          // Arrays act one cycle later
            start_o    <= run_ok;                           // High during GROW
        end
    end

    assign grid.stage = state_q;
    assign busy_o     = (state_q == GROW) || (state_q == MERGE);
    assign done_o     = (state_q == DONE);

endmodule

// ==== hdl/dg_merge_timer.sv ====
`timescale 1ns/1ps

`include "dg_config.svh"

module dg_merge_timer (
    input  logic clk,
    input  logic rst_n_i,
    input  logic start_i,
    output logic merge_last_o
);
    import dg_pkg::*;

    merge_cnt_t cnt_q;
    logic       running_q;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            cnt_q     <= '0;
            running_q <= 1'b0;
        end else if (start_i) begin
            cnt_q     <= merge_cnt_t'(`DG_MERGE_CYCLES - 1);
            running_q <= 1'b1;
        end else if (running_q) begin
            if (cnt_q == '0) running_q <= 1'b0;             // Merge phase over
            else cnt_q <= cnt_q - 1'b1;
        end
    end

    assign merge_last_o = running_q && (cnt_q == '0);

endmodule

// ==== hdl/dg_unit_array.sv ====
`timescale 1ns/1ps

`include "dg_config.svh"

module dg_unit_array (
    input  logic                                 clk,
    input  logic                                 rst_n_i,
    input  logic [`DG_GRID_X-1:0]                measurements_i,
    output dg_pkg::unit_addr_t [`DG_UNITS-1:0]   roots_o,
    dg_grid_if.units                             grid
);
    import dg_pkg::*;

    localparam int HE = `DG_GRID_X - 1;                     // In-round links per round

    unit_vec_t  meas_q;
    unit_vec_t  meas_shift;
    unit_vec_t  active_q;
    unit_vec_t  act_nxt;
    unit_addr_t root_q   [`DG_UNITS];
    unit_addr_t root_nxt [`DG_UNITS];

    // Newest row enters the top round, every other round takes the one above
    assign meas_shift = {measurements_i, meas_q[`DG_UNITS-1:`DG_GRID_X]};

    for (genvar u = 0; u < `DG_UNITS; u++) begin : g_unit
        localparam int R = u / `DG_GRID_X;
        localparam int C = u % `DG_GRID_X;

        // Directions are west, east, down, up
        localparam bit HAS [4] = '{C > 0, C < HE, R > 0, R < `DG_ROUNDS - 1};
        localparam int NB  [4] = '{
            HAS[0] ? u - 1 : u,
            HAS[1] ? u + 1 : u,
            HAS[2] ? u - `DG_GRID_X : u,
            HAS[3] ? u + `DG_GRID_X : u
        };
        localparam int EI  [4] = '{
            HAS[0] ? R * HE + C - 1 : 0,
            HAS[1] ? R * HE + C : 0,
            HAS[2] ? `DG_H_EDGES + (R - 1) * `DG_GRID_X + C : 0,
            HAS[3] ? `DG_H_EDGES + R * `DG_GRID_X + C : 0
        };

        unit_addr_t root_n;
        logic       act_n;

        // Smallest root and OR of active flags over grown links
        always_comb begin
            root_n = root_q[u];
            act_n  = active_q[u];
            for (int d = 0; d < 4; d++) begin
                if (HAS[d] && grid.edge_grown[EI[d]]) begin
                    if (root_q[NB[d]] < root_n) root_n = root_q[NB[d]];
                    act_n = act_n | active_q[NB[d]];
                end
            end
        end

        assign root_nxt[u] = root_n;
        assign act_nxt[u]  = act_n;
        assign roots_o[u]  = root_q[u];
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            meas_q   <= '0;
            active_q <= '0;
            for (int u = 0; u < `DG_UNITS; u++) root_q[u] <= unit_addr_t'(u);
        end else if (grid.clear) begin
            meas_q   <= meas_shift;
            active_q <= meas_shift;                         // A defect starts its own cluster
            for (int u = 0; u < `DG_UNITS; u++) root_q[u] <= unit_addr_t'(u);
        end else if (grid.stage == MERGE) begin
            active_q <= act_nxt;
            root_q   <= root_nxt;
        end
    end

    assign grid.unit_active = active_q;

endmodule

// ==== hdl/dg_edge_array.sv ====
`timescale 1ns/1ps

`include "dg_config.svh"

module dg_edge_array (
    input  logic     clk,
    input  logic     rst_n_i,
    dg_grid_if.edges grid
);
    import dg_pkg::*;

    localparam int HE = `DG_GRID_X - 1;
    localparam int SW = `DG_GROWTH_W + 1;                   // Sum width before saturation

    growth_t growth_q   [`DG_EDGES];
    growth_t growth_nxt [`DG_EDGES];

    for (genvar e = 0; e < `DG_EDGES; e++) begin : g_edge
        // Endpoints A and B of this link
        localparam int A = (e < `DG_H_EDGES) ? (e / HE) * `DG_GRID_X + e % HE
                                             : e - `DG_H_EDGES;
        localparam int B = (e < `DG_H_EDGES) ? A + 1 : A + `DG_GRID_X;

        logic [SW-1:0] sum;

        // Each active endpoint adds one unit of growth
        assign sum = SW'(growth_q[e]) + SW'(grid.unit_active[A]) + SW'(grid.unit_active[B]);

        assign growth_nxt[e] = (sum >= SW'(`DG_EDGE_WEIGHT)) ? growth_t'(`DG_EDGE_WEIGHT)
                                                            : sum[`DG_GROWTH_W-1:0];

        assign grid.edge_grown[e] = (growth_q[e] == growth_t'(`DG_EDGE_WEIGHT));
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int e = 0; e < `DG_EDGES; e++) growth_q[e] <= '0;
        end else if (grid.clear) begin
            for (int e = 0; e < `DG_EDGES; e++) growth_q[e] <= '0;
        end else if (grid.stage == GROW) begin
            growth_q <= growth_nxt;                         // Kept until the next load
        end
    end

endmodule

// ==== hdl/decoding_graph.sv ====
`timescale 1ns/1ps

`include "dg_config.svh"

module decoding_graph (
    input  logic                               clk,
    input  logic                               rst_n_i,
    input  logic [`DG_GRID_X-1:0]              measurements_i,
    input  logic                               load_i,
    input  logic                               run_i,
    output logic                               busy_o,
    output logic                               done_o,
    output dg_pkg::unit_addr_t [`DG_UNITS-1:0] roots_o,
    output dg_pkg::unit_vec_t                  cluster_active_o,
    output dg_pkg::edge_vec_t                  edge_grown_o
);

    logic merge_start;
    logic merge_last;

    dg_grid_if u_grid ();

    dg_stage_ctrl u_stage_ctrl (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .load_i       (load_i),
        .run_i        (run_i),
        .merge_last_i (merge_last),
        .start_o      (merge_start),
        .busy_o       (busy_o),
        .done_o       (done_o),
        .grid         (u_grid.ctrl)
    );

    dg_merge_timer u_merge_timer (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .start_i      (merge_start),
        .merge_last_o (merge_last)
    );

    dg_unit_array u_unit_array (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .measurements_i (measurements_i),
        .roots_o        (roots_o),
        .grid           (u_grid.units)
    );

    dg_edge_array u_edge_array (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .grid    (u_grid.edges)
    );

    assign cluster_active_o = u_grid.unit_active;
    assign edge_grown_o     = u_grid.edge_grown;

endmodule

// ==== test/dg_ref_model.svh ====
`ifndef DG_REF_MODEL_SVH
`define DG_REF_MODEL_SVH

bit         m_meas   [`DG_UNITS];                           // Stored measurement per unit
bit         m_active [`DG_UNITS];
unit_addr_t m_root   [`DG_UNITS];
int         m_growth [`DG_EDGES];
int         m_ea     [`DG_EDGES];                           // Lower endpoint of each link
int         m_eb     [`DG_EDGES];

// Edge table by the link ordering, then the state after reset
task automatic reset_model();
    int e;
    e = 0;
    for (int r = 0; r < `DG_ROUNDS; r++) begin
        for (int c = 0; c + 1 < `DG_GRID_X; c++) begin
            m_ea[e] = r * `DG_GRID_X + c;
            m_eb[e] = r * `DG_GRID_X + c + 1;
            e++;
        end
    end
    for (int r = 0; r + 1 < `DG_ROUNDS; r++) begin
        for (int c = 0; c < `DG_GRID_X; c++) begin
            m_ea[e] = r * `DG_GRID_X + c;
            m_eb[e] = (r + 1) * `DG_GRID_X + c;
            e++;
        end
    end
    for (int u = 0; u < `DG_UNITS; u++) begin
        m_meas[u]   = 1'b0;
        m_active[u] = 1'b0;
        m_root[u]   = unit_addr_t'(u);
    end
    for (int i = 0; i < `DG_EDGES; i++) m_growth[i] = 0;
endtask

task automatic shift_in_row(input logic [`DG_GRID_X-1:0] row);
    for (int u = 0; u < `DG_UNITS; u++) begin
        if (u < `DG_UNITS - `DG_GRID_X) m_meas[u] = m_meas[u + `DG_GRID_X];
        else m_meas[u] = row[u - (`DG_UNITS - `DG_GRID_X)];  // Newest row on top
        m_active[u] = m_meas[u];
        m_root[u]   = unit_addr_t'(u);
    end
    for (int i = 0; i < `DG_EDGES; i++) m_growth[i] = 0;
endtask

task automatic grow_edges();
    int g;
    for (int e = 0; e < `DG_EDGES; e++) begin
        g = m_growth[e] + int'(m_active[m_ea[e]]) + int'(m_active[m_eb[e]]);
        m_growth[e] = (g > `DG_EDGE_WEIGHT) ? `DG_EDGE_WEIGHT : g;
    end
endtask

// Relax over grown links until nothing moves
task automatic merge_clusters();
    bit         changed;
    unit_addr_t low;
    bit         act;
    int         a;
    int         b;
    changed = 1'b1;
    while (changed) begin
        changed = 1'b0;
        for (int e = 0; e < `DG_EDGES; e++) begin
            a = m_ea[e];
            b = m_eb[e];
            if (m_growth[e] == `DG_EDGE_WEIGHT &&
                (m_root[a] != m_root[b] || m_active[a] != m_active[b])) begin
                low = (m_root[a] < m_root[b]) ? m_root[a] : m_root[b];
                act = m_active[a] | m_active[b];
                m_root[a]   = low;
                m_root[b]   = low;
                m_active[a] = act;
                m_active[b] = act;
                changed     = 1'b1;
            end
        end
    end
endtask

`endif

// ==== test/tb_decoding_graph.sv ====
`timescale 1ns/1ps

`include "dg_config.svh"

module tb_decoding_graph;
    import dg_pkg::*;

    localparam int MC       = `DG_MERGE_CYCLES;
    localparam int N_RANDOM = 6;                            // Random loads
    localparam int N_RUNS   = 3 + N_RANDOM * 3;
    localparam int N_LOADS  = 6 + N_RANDOM;
    localparam int TIMEOUT  = N_RUNS * (MC + 4) + N_LOADS * 4 + 50;

    logic                       clk = 1'b0;
    logic                       rst_n_i;
    logic [`DG_GRID_X-1:0]      measurements_i;
    logic                       load_i;
    logic                       run_i;
    logic                       busy_o;
    logic                       done_o;
    unit_addr_t [`DG_UNITS-1:0] roots;
    unit_vec_t                  cluster_active;
    edge_vec_t                  edge_grown;
    int                         errors = 0;
    integer                     seed;

    `include "dg_ref_model.svh"

    decoding_graph DUT (
        .clk              (clk),
        .rst_n_i          (rst_n_i),
        .measurements_i   (measurements_i),
        .load_i           (load_i),
        .run_i            (run_i),
        .busy_o           (busy_o),
        .done_o           (done_o),
        .roots_o          (roots),
        .cluster_active_o (cluster_active),
        .edge_grown_o     (edge_grown)
    );

    always #2 clk = ~clk;

    done_after_busy: assert property (@(posedge clk) disable iff (!rst_n_i)
        $fell(busy_o) |-> done_o)
        else begin
            errors++;
            $display("done_o missing after busy_o fell");
        end

    done_single: assert property (@(posedge clk) disable iff (!rst_n_i)
        done_o |=> !done_o && !busy_o)
        else begin
            errors++;
            $display("done_o held too long or a run restarted");
        end

    initial begin
        repeat (TIMEOUT) @(posedge clk);
        $display("Timeout after %0d clock cycles, the test did not finish", TIMEOUT);
        $display("Errors: %0d", errors);
        $display("Simulation failed");
        $finish;
    end

    task automatic check_outputs();
        unit_vec_t exp_act;
        edge_vec_t exp_grown;
        for (int u = 0; u < `DG_UNITS; u++) begin
            exp_act[u] = m_active[u];
            assert (roots[u] == m_root[u]) else begin
                errors++;
                $display("mismatch roots_o[%0d]: got %h expected %h", u, roots[u], m_root[u]);
            end
        end
        for (int e = 0; e < `DG_EDGES; e++) exp_grown[e] = (m_growth[e] == `DG_EDGE_WEIGHT);
        assert (cluster_active == exp_act) else begin
            errors++;
            $display("mismatch cluster_active_o: got %h expected %h", cluster_active, exp_act);
        end
        assert (edge_grown == exp_grown) else begin
            errors++;
            $display("mismatch edge_grown_o: got %h expected %h", edge_grown, exp_grown);
        end
    endtask

    // Row is taken at the clear pulse one cycle after the strobe
    task automatic load_row(input logic [`DG_GRID_X-1:0] row);
        measurements_i = row;
        load_i         = 1'b1;
        @(posedge clk);
        #1 load_i = 1'b0;
        @(posedge clk);
        #1 shift_in_row(row);
    endtask

    task automatic run_once(input bit poke);
        int busy_cycles;
        int waited;
        busy_cycles = 0;
        waited      = 0;
        run_i       = 1'b1;
        @(posedge clk);
        #1 run_i = 1'b0;
        while (!done_o && waited < 2 * MC + 8) begin
            if (busy_o) busy_cycles++;
            run_i  = poke && (busy_cycles == 3);            // Ignored while busy
            load_i = poke && (busy_cycles == 5);
            if (poke) measurements_i = '1;
            @(posedge clk);
            #1 waited++;
        end
        run_i  = 1'b0;
        load_i = 1'b0;
        assert (done_o) else begin
            errors++;
            $display("run never reached done_o");
        end
        assert (busy_cycles == 1 + MC) else begin
            errors++;
            $display("mismatch busy_o cycles: got %h expected %h", busy_cycles, 1 + MC);
        end
        grow_edges();
        merge_clusters();
        check_outputs();
        @(posedge clk);
        #1;
    endtask

    initial begin
        int centre;
        int nruns;
        int near [5];
        seed           = 32'h7114;
        rst_n_i        = 1'b0;
        measurements_i = '0;
        load_i         = 1'b0;
        run_i          = 1'b0;
        reset_model();
        repeat (10) @(posedge clk);
        #1 rst_n_i = 1'b1;
        assert (!busy_o && !done_o) else begin
            errors++;
            $display("mismatch busy_o/done_o after reset: got %h/%h expected 0/0",
                     busy_o, done_o);
        end
        check_outputs();

        load_row(4'h3);
        load_row(4'hA);
        load_row(4'h5);
        assert (cluster_active == unit_vec_t'({4'h5, 4'hA, 4'h3})) else begin
            errors++;
            $display("mismatch cluster_active_o: got %h expected %h", cluster_active, 12'h5A3);
        end
        check_outputs();
        run_once(1'b1);

        // Lone defect at round 1, column 2
        load_row('0);
        load_row(4'b0100);
        load_row('0);
        run_once(1'b0);
        assert (edge_grown == '0) else begin
            errors++;
            $display("mismatch edge_grown_o: got %h expected %h", edge_grown, 0);
        end
        run_once(1'b0);
        centre = `DG_GRID_X + 2;
        near   = '{centre, centre - 1, centre + 1, centre - `DG_GRID_X, centre + `DG_GRID_X};
        for (int i = 0; i < 5; i++) begin
            assert (roots[near[i]] == unit_addr_t'(centre - `DG_GRID_X)) else begin
                errors++;
                $display("mismatch roots_o[%0d]: got %h expected %h", near[i], roots[near[i]],
                         centre - `DG_GRID_X);
            end
            assert (cluster_active[near[i]]) else begin
                errors++;
                $display("mismatch cluster_active_o[%0d]: got %h expected %h", near[i],
                         cluster_active[near[i]], 1'b1);
            end
        end
        assert ($countones(edge_grown) == 4 && $countones(cluster_active) == 5) else begin
            errors++;
            $display("single defect cluster touched other units or links");
        end

        for (int i = 0; i < N_RANDOM; i++) begin
            load_row(4'($random(seed)));
            check_outputs();
            nruns = 1 + int'($unsigned($random(seed)) % 3);
            for (int j = 0; j < nruns; j++) run_once(1'b0);
        end

        $display("Errors: %0d", errors);
        if (errors == 0) $display("Simulation passed");
        else $display("Simulation failed");
        $finish;
    end

endmodule

// ==== decoding_graph.f ====
+incdir+hdl
+incdir+test
hdl/dg_pkg.sv
hdl/dg_grid_if.sv
hdl/dg_stage_ctrl.sv
hdl/dg_merge_timer.sv
hdl/dg_unit_array.sv
hdl/dg_edge_array.sv
hdl/decoding_graph.sv
test/tb_decoding_graph.sv

// ==== Makefile ====
# Verilator build and run for the decoding graph testbench

VERILATOR ?= verilator
TOP       ?= tb_decoding_graph
FILELIST  ?= decoding_graph.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SIM     := $(BUILD_DIR)/V$(TOP)
SOURCES := $(wildcard hdl/*.sv hdl/*.svh test/*.sv test/*.svh)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	$(SIM) | tee $(LOG)
	grep -q "Simulation passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
